// ==== list.f ====
hw/plicPkg.sv
hw/plicRegs.sv
hw/plicGateway.sv
hw/plicTarget.sv
hw/plicApb.sv
verification/plicApb_checker.sv
verification/plicTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the PLIC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module plicTb -f list.f -o simPlic

out=$(./obj_dir/simPlic)
echo "$out"

if grep -q "ALL CHECKS PASSED" <<< "$out"; then
  exit 0
fi
exit 1

// ==== verification/plicTb.sv ====
`timescale 1ns/1ps

// directed testbench for the APB interrupt controller
module plicTb;

  localparam int NumSrc = 8;
  localparam int AddrW = plicPkg::addrWidth;
  localparam int TimeoutCycles = 4000;
  // enable and pending words carry sources in bits NumSrc:1
  localparam logic [31:0] SrcMask = 32'((64'h1 << (NumSrc + 1)) - 64'h2);

  logic PCLK, PRESETn, PSEL, PENABLE, PWRITE;
  logic [AddrW-1:0] PADDR;
  logic [31:0] PWDATA, PRDATA;
  logic PREADY, mExtIrq, sExtIrq;
  logic [NumSrc:1] irqSrc;

  int errors = 0;
  int cycles = 0;
  // reference copy of the priorities, slot 0 stays zero
  int prioM [0:NumSrc];

  plicApb #(.NumSrc(NumSrc)) i_plicApb (
    .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
    .PRDATA, .PREADY, .irqSrc, .mExtIrq, .sExtIrq
  );

  bind plicApb plicApb_checker apbChecker (
    .PCLK, .PRESETn, .PSEL, .PWRITE, .PRDATA, .PREADY, .mExtIrq, .sExtIrq
  );

  initial begin
    PCLK = 1'b0;
    forever #5 PCLK = ~PCLK;
  end

  // run limit, well beyond the length of all tests
  always @(posedge PCLK) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("timeout: tests did not finish within %0d cycles", TimeoutCycles);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // bus tasks and compares
  ////////////////////////////////////////////////////////////

  task automatic apbWrite(input logic [23:0] off, input logic [31:0] data);
    @(negedge PCLK);
    PSEL = 1'b1;
    PENABLE = 1'b0;
    PWRITE = 1'b1;
    PADDR = AddrW'(off);
    PWDATA = data;
    @(negedge PCLK);
    PENABLE = 1'b1;
    @(negedge PCLK);
    PSEL = 1'b0;
    PENABLE = 1'b0;
  endtask

  // data sampled mid access cycle, after the setup edge registered it
  task automatic apbRead(input logic [23:0] off, output logic [31:0] data);
    @(negedge PCLK);
    PSEL = 1'b1;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = AddrW'(off);
    @(negedge PCLK);
    PENABLE = 1'b1;
    data = PRDATA;
    @(negedge PCLK);
    PSEL = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic compareWord(input string name, input logic [31:0] expVal,
                             input logic [31:0] actVal);
    if (actVal !== expVal) begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, expVal, actVal);
    end
  endtask

  task automatic compareBit(input string name, input logic expVal, input logic actVal);
    if (actVal !== expVal) begin
      errors++;
      $display("[ERROR] %0t %s expected %b got %b", $time, name, expVal, actVal);
    end
  endtask

  task automatic checkIrq(input logic expM, input logic expS);
    @(negedge PCLK);
    compareBit("mExtIrq", expM, mExtIrq);
    compareBit("sExtIrq", expS, sExtIrq);
  endtask

  task automatic claimCheck(input int ctx, input int expId);
    logic [31:0] data;
    apbRead((ctx == 0) ? plicPkg::claimOff0 : plicPkg::claimOff1, data);
    compareWord("PRDATA claim", 32'(expId), data);
  endtask

  task automatic setPrio(input int src, input int p);
    prioM[src] = p;
    apbWrite(plicPkg::prioBase + 24'(4 * src), 32'(p));
  endtask

  // highest priority wins, ascending scan keeps the lower id on ties
  function automatic int expectClaim(input logic [31:0] en, input logic [31:0] act);
    int best;
    best = 0;
    for (int s = 1; s <= NumSrc; s++) begin
      if (act[s] && en[s] && prioM[s] > prioM[best]) begin
        best = s;
      end
    end
    return best;
  endfunction

  // reset also drops every source and clears the reference
  task automatic resetDut();
    @(negedge PCLK);
    PRESETn = 1'b0;
    irqSrc = '0;
    repeat (5) @(negedge PCLK);
    PRESETn = 1'b1;
    for (int s = 0; s <= NumSrc; s++) begin
      prioM[s] = 0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic testRegisters();
    logic [31:0] data;
    logic [31:0] wr;
    logic [23:0] cfgOff [4] = '{plicPkg::enableOff0, plicPkg::enableOff1,
                                plicPkg::threshOff0, plicPkg::threshOff1};
    logic [31:0] cfgMask [4] = '{SrcMask, SrcMask, 32'h7, 32'h7};
    // slot past NumSrc, holes in the map
    logic [23:0] holes [4] = '{24'h000024, 24'h000100, 24'h003000, 24'h200008};
    resetDut();
    for (int s = 0; s <= NumSrc; s++) begin
      wr = $urandom;
      apbWrite(plicPkg::prioBase + 24'(4 * s), wr);
      apbRead(plicPkg::prioBase + 24'(4 * s), data);
      compareWord("PRDATA prio", (s == 0) ? 32'h0 : (wr & 32'h7), data);
    end
    for (int i = 0; i < 4; i++) begin
      wr = $urandom;
      apbWrite(cfgOff[i], wr);
      apbRead(cfgOff[i], data);
      compareWord("PRDATA config", wr & cfgMask[i], data);
    end
    // writes to holes must leave nothing behind
    foreach (holes[i]) begin
      apbWrite(holes[i], $urandom);
      apbRead(holes[i], data);
      compareWord("PRDATA unmapped", 32'h0, data);
    end
  endtask

  task automatic testPending();
    logic [31:0] data;
    resetDut();
    setPrio(3, 5);
    @(negedge PCLK);
    irqSrc[3] = 1'b1;
    apbRead(plicPkg::pendOff, data);
    compareWord("PRDATA pending", 32'h8, data);
    // nothing enabled yet
    checkIrq(1'b0, 1'b0);
    apbWrite(plicPkg::enableOff0, 32'h8);
    checkIrq(1'b1, 1'b0);
  endtask

  task automatic testArbitration();
    logic [31:0] act;
    int ids [3] = '{2, 5, 7};
    int expId;
    // round 0 forces a three-way tie
    for (int round = 0; round < 4; round++) begin
      resetDut();
      act = 32'ha4;
      foreach (ids[i]) begin
        setPrio(ids[i], (round == 0) ? 4 : 1 + $urandom % 7);
      end
      apbWrite(plicPkg::enableOff0, act);
      @(negedge PCLK);
      irqSrc = act[NumSrc:1];
      // last claim finds nothing left
      for (int n = 0; n < 4; n++) begin
        expId = expectClaim(32'ha4, act);
        claimCheck(0, expId);
        if (expId != 0) begin
          act[expId] = 1'b0;
        end
      end
    end
  endtask

  task automatic testThreshold();
    logic [31:0] act;
    int best;
    resetDut();
    // source 6 keeps priority 0 from reset
    act = 32'h50;
    setPrio(4, 1 + $urandom % 7);
    apbWrite(plicPkg::enableOff0, act);
    @(negedge PCLK);
    irqSrc = act[NumSrc:1];
    for (int th = 0; th < 8; th++) begin
      apbWrite(plicPkg::threshOff0, 32'(th));
      best = prioM[expectClaim(act, act)];
      checkIrq(best > th, 1'b0);
    end
    apbWrite(plicPkg::threshOff0, 32'h0);
    setPrio(4, 0);
    checkIrq(1'b0, 1'b0);
  endtask

  task automatic testClaimComplete();
    logic [31:0] data;
    resetDut();
    setPrio(3, 2);
    apbWrite(plicPkg::enableOff0, 32'h8);
    @(negedge PCLK);
    irqSrc[3] = 1'b1;
    claimCheck(0, 3);
    claimCheck(0, 0);
    // level still high, blocked while in progress
    apbRead(plicPkg::pendOff, data);
    compareWord("PRDATA pending", 32'h0, data);
    checkIrq(1'b0, 1'b0);
    apbWrite(plicPkg::claimOff0, 32'd3);
    apbRead(plicPkg::pendOff, data);
    compareWord("PRDATA pending", 32'h8, data);
    checkIrq(1'b1, 1'b0);
    // dropped before completion
    claimCheck(0, 3);
    @(negedge PCLK);
    irqSrc[3] = 1'b0;
    apbWrite(plicPkg::claimOff0, 32'd3);
    apbRead(plicPkg::pendOff, data);
    compareWord("PRDATA pending", 32'h0, data);
    checkIrq(1'b0, 1'b0);
  endtask

  task automatic testContexts();
    logic [31:0] act;
    int expId;
    resetDut();
    act = 32'h1e;
    for (int s = 1; s <= 4; s++) begin
      setPrio(s, 1 + $urandom % 7);
    end
    // machine owns 1 and 2 but is masked by its threshold
    apbWrite(plicPkg::enableOff0, 32'h06);
    apbWrite(plicPkg::enableOff1, 32'h18);
    apbWrite(plicPkg::threshOff0, 32'h7);
    @(negedge PCLK);
    irqSrc = act[NumSrc:1];
    checkIrq(1'b0, 1'b1);
    for (int n = 0; n < 3; n++) begin
      expId = expectClaim(32'h18, act);
      claimCheck(1, expId);
      if (expId != 0) begin
        act[expId] = 1'b0;
      end
    end
    checkIrq(1'b0, 1'b0);
  endtask

  initial begin
    void'($urandom(32'h83ed));
    PRESETn = 1'b0;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = '0;
    PWDATA = '0;
    irqSrc = '0;
    testRegisters();
    testPending();
    testArbitration();
    testThreshold();
    testClaimComplete();
    testContexts();
    $display("summary: %0d errors", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== verification/plicApb_checker.sv ====
`timescale 1ns/1ps

// bound into plicApb
// watches the APB slave response and the interrupt lines
module plicApb_checker (
  input logic        PCLK,
  input logic        PRESETn,
  input logic        PSEL,
  input logic        PWRITE,
  input logic [31:0] PRDATA,
  input logic        PREADY,
  input logic        mExtIrq,
  input logic        sExtIrq
);

  ////////////////////////////////////////////////////////////
  // APB response
  ////////////////////////////////////////////////////////////

  // zero wait states, every access completes in one cycle
  readyHigh: assert property (@(posedge PCLK) PREADY)
    else $error("PREADY went low");

  // no read in this cycle means zero read data in the next
  rdataIdle: assert property (@(posedge PCLK) disable iff (!PRESETn)
      !(PSEL && !PWRITE) |=> (PRDATA == 32'h0))
    else $error("PRDATA nonzero after a cycle without a read");

  ////////////////////////////////////////////////////////////
  // interrupt lines
  ////////////////////////////////////////////////////////////

  // a reset edge clears pending and config, so both lines drop
  irqLowInReset: assert property (@(posedge PCLK) !PRESETn |=> (!mExtIrq && !sExtIrq))
    else $error("interrupt line high while in reset");

endmodule

// ==== hw/plicApb.sv ====
`timescale 1ns/1ps

// platform-level interrupt controller, APB slave
// one hart with machine and supervisor contexts
module plicApb #(
  parameter int NumSrc = 8
) (
  input  logic                          PCLK,
  input  logic                          PRESETn,
  input  logic                          PSEL,
  input  logic                          PENABLE,
  input  logic                          PWRITE,
  input  logic [plicPkg::addrWidth-1:0] PADDR,
  input  logic [31:0]                   PWDATA,
  output logic [31:0]                   PRDATA,
  output logic                          PREADY,
  input  logic [NumSrc:1]               irqSrc,
  output logic                          mExtIrq,
  output logic                          sExtIrq
);

  // configuration from the register file
  logic [NumSrc:1][plicPkg::prioWidth-1:0] prio;
  logic [NumSrc:1]                         enable0;
  logic [NumSrc:1]                         enable1;
  logic [plicPkg::prioWidth-1:0]           thresh0;
  logic [plicPkg::prioWidth-1:0]           thresh1;
  // claim and completion pulses
  logic                                    claimStb;
  logic [plicPkg::idWidth-1:0]             claimId;
  logic                                    completeStb;
  logic [plicPkg::idWidth-1:0]             completeId;
  // gateway state and per-context winners
  logic [NumSrc:1]                         pending;
  logic [plicPkg::idWidth-1:0]             claimId0;
  logic [plicPkg::idWidth-1:0]             claimId1;

  // every access completes in one cycle
  assign PREADY = 1'b1;

  plicRegs #(.NumSrc(NumSrc)) regs (
    .PCLK, .PRESETn, .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
    .pending, .claimId0, .claimId1, .PRDATA,
    .prio, .enable0, .enable1, .thresh0, .thresh1,
    .claimStb, .claimId, .completeStb, .completeId
  );

  plicGateway #(.NumSrc(NumSrc)) gateway (
    .PCLK, .PRESETn, .irqSrc,
    .claimStb, .claimId, .completeStb, .completeId, .pending
  );

  // machine context
  plicTarget #(.NumSrc(NumSrc)) target0 (
    .pending, .enable(enable0), .prio, .thresh(thresh0),
    .claimId(claimId0), .extIrq(mExtIrq)
  );

  // supervisor context
  plicTarget #(.NumSrc(NumSrc)) target1 (
    .pending, .enable(enable1), .prio, .thresh(thresh1),
    .claimId(claimId1), .extIrq(sExtIrq)
  );

endmodule

// ==== hw/plicTarget.sv ====
`timescale 1ns/1ps

// arbitration for one context
// picks the winning source id and drives the external interrupt line
module plicTarget #(
  parameter int NumSrc = 8
) (
  input  logic [NumSrc:1]                         pending,
  input  logic [NumSrc:1]                         enable,
  input  logic [NumSrc:1][plicPkg::prioWidth-1:0] prio,
  input  logic [plicPkg::prioWidth-1:0]           thresh,
  output logic [plicPkg::idWidth-1:0]             claimId,
  output logic                                    extIrq
);

  localparam int IdW      = plicPkg::idWidth;
  // highest priority level, level 0 never requests
  localparam int TopLevel = (1 << plicPkg::prioWidth) - 1;

  // reqMatrix[lvl][src] is an enabled, pending source at that level
  logic [TopLevel:1][NumSrc:1] reqMatrix;
  logic [TopLevel:1]           levelActive;
  // one-hot, the highest active level
  logic [TopLevel:1]           levelIsMax;
  logic [TopLevel:1]           aboveThresh;
  // requests sitting at the winning level
  logic [NumSrc:1]             maxReqs;

  ////////////////////////////////////////////////////////////
  // request matrix
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int lvl = 1; lvl <= TopLevel; lvl++) begin
      for (int src = 1; src <= NumSrc; src++) begin
        reqMatrix[lvl][src] = pending[src] & enable[src] & (int'(prio[src]) == lvl);
      end
      levelActive[lvl] = |reqMatrix[lvl];
      aboveThresh[lvl] = (lvl > int'(thresh));
    end
  end

  ////////////////////////////////////////////////////////////
  // winner selection
  ////////////////////////////////////////////////////////////

  // scan from the top level down, first active level wins
  always_comb begin
    logic higher;
    higher     = 1'b0;
    levelIsMax = '0;
    for (int lvl = TopLevel; lvl >= 1; lvl--) begin
      levelIsMax[lvl] = levelActive[lvl] & ~higher;
      higher          = higher | levelActive[lvl];
    end
  end

  always_comb begin
    maxReqs = '0;
    for (int lvl = 1; lvl <= TopLevel; lvl++) begin
      if (levelIsMax[lvl]) begin
        maxReqs = maxReqs | reqMatrix[lvl];
      end
    end
  end

  // descending scan so the lowest id among ties ends up in claimId
  always_comb begin
    claimId = '0;
    for (int src = NumSrc; src >= 1; src--) begin
      if (maxReqs[src]) begin
        claimId = IdW'(src);
      end
    end
  end

  // interrupt when any active level is strictly above threshold
  assign extIrq = |(levelActive & aboveThresh);

endmodule

// ==== hw/plicGateway.sv ====
`timescale 1ns/1ps

// level-triggered gateways
// holds pending and in-progress state for every source
module plicGateway #(
  parameter int NumSrc = 8
) (
  input  logic                        PCLK,
  input  logic                        PRESETn,
  input  logic [NumSrc:1]             irqSrc,
  input  logic                        claimStb,
  input  logic [plicPkg::idWidth-1:0] claimId,
  input  logic                        completeStb,
  input  logic [plicPkg::idWidth-1:0] completeId,
  output logic [NumSrc:1]             pending
);

  logic [NumSrc:1] inProgress;
  // one-hot set and clear masks for in-progress
  logic [NumSrc:1] claimMask;
  logic [NumSrc:1] completeMask;

  // id 0 and ids above NumSrc match no bit
  always_comb begin
    for (int src = 1; src <= NumSrc; src++) begin
      claimMask[src]    = claimStb & (int'(claimId) == src);
      completeMask[src] = completeStb & (int'(completeId) == src);
    end
  end

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      pending    <= '0;
      inProgress <= '0;
    end else begin
      // a source being serviced cannot raise a new request
      pending    <= (pending | irqSrc) & ~inProgress;
      inProgress <= (inProgress | claimMask) & ~completeMask;
    end
  end

endmodule

// ==== hw/plicRegs.sv ====
`timescale 1ns/1ps

// APB register file
// priorities, enables, thresholds, pending view and claim/complete decode
module plicRegs #(
  parameter int NumSrc = 8
) (
  input  logic                                      PCLK,
  input  logic                                      PRESETn,
  input  logic                                      PSEL,
  input  logic                                      PENABLE,
  input  logic                                      PWRITE,
  input  logic [plicPkg::addrWidth-1:0]             PADDR,
  input  logic [31:0]                               PWDATA,
  input  logic [NumSrc:1]                           pending,
  input  logic [plicPkg::idWidth-1:0]               claimId0,
  input  logic [plicPkg::idWidth-1:0]               claimId1,
  output logic [31:0]                               PRDATA,
  output logic [NumSrc:1][plicPkg::prioWidth-1:0]   prio,
  output logic [NumSrc:1]                           enable0,
  output logic [NumSrc:1]                           enable1,
  output logic [plicPkg::prioWidth-1:0]             thresh0,
  output logic [plicPkg::prioWidth-1:0]             thresh1,
  output logic                                      claimStb,
  output logic [plicPkg::idWidth-1:0]               claimId,
  output logic                                      completeStb,
  output logic [plicPkg::idWidth-1:0]               completeId
);

  // word-aligned offset inside the 24-bit window
  logic [23:0]                        entry;
  logic                               busWrite;
  logic                               busRead;
  // priority slot decode
  logic                               prioHit;
  logic [plicPkg::idWidth-1:0]        prioIdx;
  // one hit bit per context claim register
  logic [plicPkg::numCtx-1:0]         claimHit;
  logic [plicPkg::numCtx-1:0][plicPkg::idWidth-1:0] ctxClaim;
  logic [31:0]                        rdData;

  ////////////////////////////////////////////////////////////
  // bus decode
  ////////////////////////////////////////////////////////////

  assign entry    = {PADDR[23:2], 2'b00};
  // writes land at the end of the access cycle
  assign busWrite = PSEL & PENABLE & PWRITE;
  // reads are sampled in setup and access cycles alike
  assign busRead  = PSEL & ~PWRITE;

  // priority slots occupy the lowest 32 words
  assign prioHit = (entry[23:plicPkg::idWidth+2] == plicPkg::prioBase[23:plicPkg::idWidth+2]);
  assign prioIdx = entry[plicPkg::idWidth+1:2];

  assign claimHit[0] = (entry == plicPkg::claimOff0);
  assign claimHit[1] = (entry == plicPkg::claimOff1);
  assign ctxClaim[0] = claimId0;
  assign ctxClaim[1] = claimId1;

  // claim fires once, in the setup cycle of the read
  assign claimStb = busRead & ~PENABLE & (|claimHit);
  assign claimId  = claimHit[1] ? ctxClaim[1] : ctxClaim[0];

  // a write to either claim register completes the written id
  assign completeStb = busWrite & (|claimHit);
  assign completeId  = PWDATA[plicPkg::idWidth-1:0];

  ////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      prio    <= '0;
      enable0 <= '0;
      enable1 <= '0;
      thresh0 <= '0;
      thresh1 <= '0;
    end else if (busWrite) begin
      // slot 0 and slots past NumSrc have no storage
      for (int src = 1; src <= NumSrc; src++) begin
        if (prioHit && int'(prioIdx) == src) begin
          prio[src] <= PWDATA[plicPkg::prioWidth-1:0];
        end
      end
      case (entry)
        plicPkg::enableOff0: enable0 <= PWDATA[NumSrc:1];
        plicPkg::enableOff1: enable1 <= PWDATA[NumSrc:1];
        plicPkg::threshOff0: thresh0 <= PWDATA[plicPkg::prioWidth-1:0];
        plicPkg::threshOff1: thresh1 <= PWDATA[plicPkg::prioWidth-1:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    rdData = '0;
    for (int src = 1; src <= NumSrc; src++) begin
      if (prioHit && int'(prioIdx) == src) begin
        rdData[plicPkg::prioWidth-1:0] = prio[src];
      end
    end
    // bit 0 of pending and enable words stays zero
    case (entry)
      plicPkg::pendOff:    rdData[NumSrc:1] = pending;
      plicPkg::enableOff0: rdData[NumSrc:1] = enable0;
      plicPkg::enableOff1: rdData[NumSrc:1] = enable1;
      plicPkg::threshOff0: rdData[plicPkg::prioWidth-1:0] = thresh0;
      plicPkg::threshOff1: rdData[plicPkg::prioWidth-1:0] = thresh1;
      plicPkg::claimOff0:  rdData[plicPkg::idWidth-1:0] = ctxClaim[0];
      plicPkg::claimOff1:  rdData[plicPkg::idWidth-1:0] = ctxClaim[1];
      default: ;
    endcase
  end

  // registered read data, valid in the access cycle
  // a claim keeps the id captured in setup so the data matches the in-progress bit
  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      PRDATA <= '0;
    end else if (!busRead) begin
      PRDATA <= '0;
    end else if (!(PENABLE && (|claimHit))) begin
      PRDATA <= rdData;
    end
  end

endmodule

// ==== hw/plicPkg.sv ====
// shared constants for the platform-level interrupt controller
// one hart, machine and supervisor contexts

package plicPkg;

  // context count
  // index 0 is machine, index 1 is supervisor
  parameter int numCtx = 2;

  // priority and threshold width
  parameter int prioWidth = 3;

  // source id width, id 0 means no interrupt
  parameter int idWidth = 5;

  // APB address width
  parameter int addrWidth = 28;

  ////////////////////////////////////////////////////////////
  // register map, byte offsets into the 24-bit window
  ////////////////////////////////////////////////////////////

  // priority of source n sits at prioBase + 4*n
  parameter logic [23:0] prioBase   = 24'h000000;
  parameter logic [23:0] pendOff    = 24'h001000;
  parameter logic [23:0] enableOff0 = 24'h002000;
  parameter logic [23:0] enableOff1 = 24'h002080;
  parameter logic [23:0] threshOff0 = 24'h200000;
  parameter logic [23:0] claimOff0  = 24'h200004;
  parameter logic [23:0] threshOff1 = 24'h201000;
  parameter logic [23:0] claimOff1  = 24'h201004;

endpackage
